// ==== Bender.yml ====
package:
  name: ctlboard

sources:
  - design/ctlPkg.sv
  - design/regCtlIf.sv
  - design/ctlDecode.sv
  - design/diagDecode.sv
  - design/arDatapath.sv
  - design/ctlTop.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/ctlTb.sv

// ==== build.f ====
+incdir+tb
design/ctlPkg.sv
design/regCtlIf.sv
design/ctlDecode.sv
design/diagDecode.sv
design/arDatapath.sv
design/ctlTop.sv
tb/ctlTb.sv

// ==== design/arDatapath.sv ====
`timescale 1ns/1ps

module arDatapath (
  input logic CTL,
  input logic reset,
  input logic step,
  input ctlPkg::wordT memData,
  input logic diagArLoad,
  input ctlPkg::wordT diagData,
  regCtlIf.datapath ctl,
  output ctlPkg::wordT ar,
  output ctlPkg::wordT arx,
  output ctlPkg::wordT mq
);

  ctlPkg::wordT ad;
  ctlPkg::halfT arlNext;
  ctlPkg::halfT arrNext;
  ctlPkg::wordT arxNext;
  ctlPkg::wordT mqNext;

  function automatic ctlPkg::halfT pickHalf(
    input ctlPkg::arFieldT sel,
    input ctlPkg::halfT fromAd,
    input ctlPkg::halfT fromMem,
    input ctlPkg::halfT fromArx,
    input ctlPkg::halfT current
  );
    case (sel)
      ctlPkg::arSrcAd: pickHalf = fromAd;
      ctlPkg::arSrcMem: pickHalf = fromMem;
      ctlPkg::arSrcArx: pickHalf = fromArx;
      default: pickHalf = current;
    endcase
  endfunction

  // AD, carry out of bit 0 is lost
  assign ad = ar + arx + ctlPkg::wordT'(ctl.adCarryIn);

  // AR halves pick their sources independently
  always_comb begin
    if (ctl.arlClr) begin
      arlNext = '0;
    end else if (ctl.arlLoad) begin
      arlNext = pickHalf(ctl.arlSel, ad[0:17], memData[0:17], arx[0:17], ar[0:17]);
    end else begin
      arlNext = ar[0:17];
    end

    if (ctl.arrClr) begin
      arrNext = '0;
    end else if (ctl.arrLoad) begin
      arrNext = pickHalf(ctl.arrSel, ad[18:35], memData[18:35], arx[18:35], ar[18:35]);
    end else begin
      arrNext = ar[18:35];
    end
  end

  always_comb begin
    arxNext = arx;
    if (ctl.arxClr) begin
      arxNext = '0;
    end else if (ctl.arxLoad) begin
      case (ctl.arxSel)
        ctlPkg::arxSrcAr: arxNext = ar;
        ctlPkg::arxSrcMem: arxNext = memData;
        ctlPkg::arxSrcAd: arxNext = ad;
        default: arxNext = arx;
      endcase
    end

    // Shift toward bit 0, AR sign enters at the bottom
    if (ctl.mqShift) begin
      mqNext = {mq[1:35], ar[0]};
    end else if (ctl.mqLoad) begin
      mqNext = ar;
    end else begin
      mqNext = mq;
    end
  end

  always_ff @(posedge CTL) begin
    if (reset) begin
      ar <= '0;
      arx <= '0;
      mq <= '0;
    end else begin
      // Console load reaches AR even with the clock stopped
      if (diagArLoad) begin
        ar <= diagData;
      end else if (step) begin
        ar <= {arlNext, arrNext};
      end
      if (step) begin
        arx <= arxNext;
        mq <= mqNext;
      end
    end
  end

endmodule

// ==== design/ctlDecode.sv ====
`timescale 1ns/1ps

module ctlDecode (
  input ctlPkg::arFieldT crAr,
  input ctlPkg::arxFieldT crArx,
  input logic crMq,
  input logic crAdCarry,
  input ctlPkg::specT crSpec,
  input ctlPkg::condT crCond,
  input ctlPkg::magicT crMagic,
  input logic arBit0,
  regCtlIf.decode ctl
);

  logic condEn;
  logic [0:2] condCode;

  logic hitArlLoad;
  logic hitArrLoad;
  logic hitArClr;
  logic hitArxClr;
  logic hitArlInd;

  logic specXcry;
  logic specShift;
  logic specInd;

  logic indMode;
  ctlPkg::arFieldT indSel;

  // A condition load with no AR source still needs one, it takes AD
  function automatic ctlPkg::arFieldT halfSel(
    input ctlPkg::arFieldT field,
    input logic condLoad
  );
    if (condLoad && field == ctlPkg::arSrcNone) begin
      halfSel = ctlPkg::arSrcAd;
    end else begin
      halfSel = field;
    end
  endfunction

  function automatic logic halfLoad(
    input ctlPkg::arFieldT field,
    input logic condLoad
  );
    halfLoad = (field != ctlPkg::arSrcNone) || condLoad;
  endfunction

  // Condition field
  always_comb begin
    condEn = crCond[0:2] == 3'b000;
    condCode = crCond[3:5];
    hitArlLoad = condEn && condCode == ctlPkg::condArlLoad[3:5];
    hitArrLoad = condEn && condCode == ctlPkg::condArrLoad[3:5];
    hitArClr = condEn && condCode == ctlPkg::condArClr[3:5];
    hitArxClr = condEn && condCode == ctlPkg::condArxClr[3:5];
    hitArlInd = condEn && condCode == ctlPkg::condArlInd[3:5];
  end

  // Special functions
  always_comb begin
    specXcry = crSpec == ctlPkg::specXcryAr0;
    specShift = crSpec == ctlPkg::specMqShift;
    specInd = crSpec == ctlPkg::specArlInd;
  end

  always_comb begin
    indMode = specInd || hitArlInd;
    indSel = crMagic[6:7];
    ctl.arlInd = indMode;

    // Right half always follows crAr
    ctl.arrSel = halfSel(crAr, hitArrLoad);
    ctl.arrLoad = halfLoad(crAr, hitArrLoad);
    ctl.arrClr = hitArClr;

    // Left half is steered by the magic field in indirect mode
    if (indMode) begin
      ctl.arlSel = indSel;
      ctl.arlLoad = indSel != ctlPkg::arSrcNone;
      ctl.arlClr = crMagic[4] || hitArClr;
    end else begin
      ctl.arlSel = halfSel(crAr, hitArlLoad);
      ctl.arlLoad = halfLoad(crAr, hitArlLoad);
      ctl.arlClr = hitArClr;
    end
  end

  always_comb begin
    ctl.arxSel = crArx;
    ctl.arxLoad = crArx != ctlPkg::arxSrcHold;
    ctl.arxClr = hitArxClr;

    ctl.mqLoad = crMq;
    ctl.mqShift = specShift;

    // Carry into bit 35 of AD, flipped by AR sign under XCRY AR0
    ctl.adCarryIn = crAdCarry ^ (arBit0 & specXcry);
  end

endmodule

// ==== design/ctlPkg.sv ====
package ctlPkg;

  // Machine word, bit 0 is the most significant
  typedef logic [0:35] wordT;
  typedef logic [0:17] halfT;

  // Microword fields
  typedef logic [0:1] arFieldT;
  typedef logic [0:1] arxFieldT;
  typedef logic [0:3] specT;
  typedef logic [0:5] condT;
  typedef logic [0:8] magicT;

  // Console function code, written in octal
  typedef logic [0:6] diagFuncT;

  // Readback group and diagnostic register
  typedef logic [0:4] diagGroupT;

  // AR source codes, per half
  localparam arFieldT arSrcNone = 2'd0;
  localparam arFieldT arSrcAd = 2'd1;
  localparam arFieldT arSrcMem = 2'd2;
  localparam arFieldT arSrcArx = 2'd3;

  // ARX source codes
  localparam arxFieldT arxSrcHold = 2'd0;
  localparam arxFieldT arxSrcAr = 2'd1;
  localparam arxFieldT arxSrcMem = 2'd2;
  localparam arxFieldT arxSrcAd = 2'd3;

  // Special functions
  localparam specT specNone = 4'd0;
  localparam specT specXcryAr0 = 4'd1;
  localparam specT specMqShift = 4'd2;
  localparam specT specArlInd = 4'd3;

  // Condition codes, only enabled with upper three bits clear
  // Codes 3 and 7 are reserved
  localparam condT condArlLoad = 6'd1;
  localparam condT condArrLoad = 6'd2;
  localparam condT condArClr = 6'd4;
  localparam condT condArxClr = 6'd5;
  localparam condT condArlInd = 6'd6;

  // Console functions
  localparam diagFuncT diagLdReg = 7'o076;
  localparam diagFuncT diagArLoad = 7'o077;
  // Reads are 0100 through 0107, low digit picks the group
  localparam diagFuncT diagReadBase = 7'o100;

endpackage

// ==== design/ctlTop.sv ====
`timescale 1ns/1ps

module ctlTop (
  input logic CTL,
  input logic reset,
  input logic step,

  // Microword
  input ctlPkg::arFieldT crAr,
  input ctlPkg::arxFieldT crArx,
  input logic crMq,
  input logic crAdCarry,
  input ctlPkg::specT crSpec,
  input ctlPkg::condT crCond,
  input ctlPkg::magicT crMagic,

  input ctlPkg::wordT memData,

  // Console
  input ctlPkg::diagFuncT diagFunc,
  input logic diagStrobe,
  input ctlPkg::wordT diagDataIn,

  output ctlPkg::wordT ar,
  output ctlPkg::wordT arx,
  output ctlPkg::wordT mq,
  output ctlPkg::wordT diagDataOut,
  output logic diagDriving,
  output logic memReset
);

  logic diagArLoad;
  ctlPkg::wordT diagData;

  regCtlIf regCtl_i ();

  // AR sign feeds back for XCRY AR0
  ctlDecode ctlDecode_i (
    .crAr(crAr),
    .crArx(crArx),
    .crMq(crMq),
    .crAdCarry(crAdCarry),
    .crSpec(crSpec),
    .crCond(crCond),
    .crMagic(crMagic),
    .arBit0(ar[0]),
    .ctl(regCtl_i.decode)
  );

  arDatapath arDatapath_i (
    .CTL(CTL),
    .reset(reset),
    .step(step),
    .memData(memData),
    .diagArLoad(diagArLoad),
    .diagData(diagData),
    .ctl(regCtl_i.datapath),
    .ar(ar),
    .arx(arx),
    .mq(mq)
  );

  diagDecode diagDecode_i (
    .CTL(CTL),
    .reset(reset),
    .diagFunc(diagFunc),
    .diagStrobe(diagStrobe),
    .diagDataIn(diagDataIn),
    .ctl(regCtl_i.monitor),
    .diagArLoad(diagArLoad),
    .diagData(diagData),
    .diagDataOut(diagDataOut),
    .diagDriving(diagDriving),
    .memReset(memReset)
  );

endmodule

// ==== design/diagDecode.sv ====
`timescale 1ns/1ps

module diagDecode (
  input logic CTL,
  input logic reset,
  input ctlPkg::diagFuncT diagFunc,
  input logic diagStrobe,
  input ctlPkg::wordT diagDataIn,
  regCtlIf.monitor ctl,
  output logic diagArLoad,
  output ctlPkg::wordT diagData,
  output ctlPkg::wordT diagDataOut,
  output logic diagDriving,
  output logic memReset
);

  logic ldReg;
  logic readHit;
  logic [0:2] readGroup;

  ctlPkg::diagGroupT diagReg;
  ctlPkg::diagGroupT groupVal;

  // Function decode, all qualified by the strobe
  always_comb begin
    ldReg = diagStrobe && diagFunc == ctlPkg::diagLdReg;
    diagArLoad = diagStrobe && diagFunc == ctlPkg::diagArLoad;
    readHit = diagStrobe && diagFunc[0:3] == ctlPkg::diagReadBase[0:3];
    readGroup = diagFunc[4:6];
  end

  // Console data goes straight to AR on a 077 load
  assign diagData = diagDataIn;

  always_ff @(posedge CTL) begin
    if (reset) begin
      diagReg <= '0;
    end else if (ldReg) begin
      diagReg <= diagDataIn[24:28];
    end
  end

  assign memReset = diagReg[0];

  // Group select
  always_comb begin
    case (readGroup)
      3'd0: begin
        groupVal = {ctl.arlLoad, ctl.arrLoad, ctl.arxLoad, ctl.mqLoad, ctl.arlInd};
      end
      3'd1: begin
        groupVal = {ctl.arlClr, ctl.arrClr, ctl.arxClr, ctl.mqShift, ctl.adCarryIn};
      end
      3'd7: begin
        groupVal = diagReg;
      end
      default: begin
        groupVal = '0;
      end
    endcase
  end

  // Read data sits in bits 24-28, the rest of the bus stays zero
  always_comb begin
    diagDriving = readHit;
    diagDataOut = '0;
    if (readHit) begin
      diagDataOut[24:28] = groupVal;
    end
  end

endmodule

// ==== design/regCtlIf.sv ====
`timescale 1ns/1ps

interface regCtlIf;

  // AR halves
  ctlPkg::arFieldT arlSel;
  ctlPkg::arFieldT arrSel;
  logic arlLoad;
  logic arrLoad;
  logic arlClr;
  logic arrClr;

  // ARX
  ctlPkg::arxFieldT arxSel;
  logic arxLoad;
  logic arxClr;

  // MQ and adder
  logic mqLoad;
  logic mqShift;
  logic adCarryIn;

  // Left half under magic field control
  logic arlInd;

  modport decode (
    output arlSel, arrSel, arlLoad, arrLoad, arlClr, arrClr,
    output arxSel, arxLoad, arxClr, mqLoad, mqShift, adCarryIn, arlInd
  );

  modport datapath (
    input arlSel, arrSel, arlLoad, arrLoad, arlClr, arrClr,
    input arxSel, arxLoad, arxClr, mqLoad, mqShift, adCarryIn
  );

  modport monitor (
    input arlLoad, arrLoad, arxLoad, mqLoad, arlInd,
    input arlClr, arrClr, arxClr, mqShift, adCarryIn
  );

endinterface

// ==== tb/ctlTbTasks.svh ====
// Galois LFSR, one step per bit taken
function automatic logic lfsrBit();
  logic outBit;
  outBit = lfsr[0];
  lfsr = lfsr >> 1;
  if (outBit) begin
    lfsr = lfsr ^ 32'hD000_0001;
  end
  return outBit;
endfunction

function automatic ctlPkg::wordT randWord();
  ctlPkg::wordT w;
  w = '0;
  for (int i = 0; i < 36; i++) begin
    w = {w[1:35], lfsrBit()};
  end
  return w;
endfunction

// 36-bit sum, carry out lost
function automatic ctlPkg::wordT modelAd(
  input ctlPkg::wordT a,
  input ctlPkg::wordT x,
  input logic cin
);
  logic [36:0] sum;
  sum = {1'b0, a} + {1'b0, x} + {36'd0, cin};
  return sum[35:0];
endfunction

// Readback group placed in bits 24-28
function automatic ctlPkg::wordT groupWord(input logic [0:4] g);
  ctlPkg::wordT w;
  w = '0;
  w[24:28] = g;
  return w;
endfunction

task automatic consoleLoad(input ctlPkg::diagFuncT func, input ctlPkg::wordT data);
  diagFunc = func;
  diagDataIn = data;
  diagStrobe = 1'b1;
  @(negedge CTL);
  diagStrobe = 1'b0;
endtask

task automatic readBack(input ctlPkg::diagFuncT func, input logic [0:4] grp);
  diagFunc = func;
  diagStrobe = 1'b1;
  @(negedge CTL);
  checkWord("diagDataOut", diagDataOut, groupWord(grp));
  checkBit("diagDriving", diagDriving, 1'b1);
  diagStrobe = 1'b0;
endtask

task automatic testReset();
  eAr = '0;
  eArx = '0;
  eMq = '0;
  checkRegs();
  checkWord("diagDataOut", diagDataOut, '0);
  checkBit("diagDriving", diagDriving, 1'b0);
  checkBit("memReset", memReset, 1'b0);
endtask

task automatic testLoadsAd();
  memData = randWord();
  stepWord(ctlPkg::arSrcMem, ctlPkg::arxSrcHold, 1'b0, 1'b0, ctlPkg::specNone, '0, '0);
  eAr = memData;
  checkRegs();
  stepWord(ctlPkg::arSrcNone, ctlPkg::arxSrcAr, 1'b0, 1'b0, ctlPkg::specNone, '0, '0);
  eArx = eAr;
  checkRegs();
  memData = randWord();
  stepWord(ctlPkg::arSrcMem, ctlPkg::arxSrcHold, 1'b0, 1'b0, ctlPkg::specNone, '0, '0);
  eAr = memData;
  checkRegs();
  stepWord(ctlPkg::arSrcAd, ctlPkg::arxSrcHold, 1'b0, 1'b0, ctlPkg::specNone, '0, '0);
  eAr = modelAd(eAr, eArx, 1'b0);
  checkRegs();
  stepWord(ctlPkg::arSrcAd, ctlPkg::arxSrcHold, 1'b0, 1'b1, ctlPkg::specNone, '0, '0);
  eAr = modelAd(eAr, eArx, 1'b1);
  checkRegs();
  // XCRY AR0 with the sign set, then clear
  memData = randWord() | signBit;
  stepWord(ctlPkg::arSrcMem, ctlPkg::arxSrcHold, 1'b0, 1'b0, ctlPkg::specNone, '0, '0);
  eAr = memData;
  stepWord(ctlPkg::arSrcAd, ctlPkg::arxSrcHold, 1'b0, 1'b0, ctlPkg::specXcryAr0, '0, '0);
  eAr = modelAd(eAr, eArx, 1'b1);
  checkRegs();
  memData = randWord() & ~signBit;
  stepWord(ctlPkg::arSrcMem, ctlPkg::arxSrcHold, 1'b0, 1'b0, ctlPkg::specNone, '0, '0);
  eAr = memData;
  stepWord(ctlPkg::arSrcAd, ctlPkg::arxSrcHold, 1'b0, 1'b0, ctlPkg::specXcryAr0, '0, '0);
  eAr = modelAd(eAr, eArx, 1'b0);
  checkRegs();
endtask

task automatic testCond();
  ctlPkg::wordT sum;
  sum = modelAd(eAr, eArx, 1'b0);
  stepWord(ctlPkg::arSrcNone, ctlPkg::arxSrcHold, 1'b0, 1'b0, ctlPkg::specNone,
    ctlPkg::condArlLoad, '0);
  eAr = {sum[0:17], eAr[18:35]};
  checkRegs();
  sum = modelAd(eAr, eArx, 1'b0);
  stepWord(ctlPkg::arSrcNone, ctlPkg::arxSrcHold, 1'b0, 1'b0, ctlPkg::specNone,
    ctlPkg::condArrLoad, '0);
  eAr = {eAr[0:17], sum[18:35]};
  checkRegs();
  memData = randWord();
  stepWord(ctlPkg::arSrcMem, ctlPkg::arxSrcHold, 1'b0, 1'b0, ctlPkg::specNone,
    ctlPkg::condArClr, '0);
  eAr = '0;
  checkRegs();
  stepWord(ctlPkg::arSrcMem, ctlPkg::arxSrcMem, 1'b0, 1'b0, ctlPkg::specNone,
    ctlPkg::condArxClr, '0);
  eAr = memData;
  eArx = '0;
  checkRegs();
  memData = randWord();
  stepWord(ctlPkg::arSrcNone, ctlPkg::arxSrcMem, 1'b0, 1'b0, ctlPkg::specNone, '0, '0);
  eArx = memData;
  checkRegs();
endtask

task automatic testIndirect();
  ctlPkg::magicT mg;
  ctlPkg::wordT sum;
  mg = '0;
  mg[6:7] = ctlPkg::arSrcMem;
  memData = randWord();
  stepWord(ctlPkg::arSrcArx, ctlPkg::arxSrcHold, 1'b0, 1'b0, ctlPkg::specArlInd, '0, mg);
  eAr = {memData[0:17], eArx[18:35]};
  checkRegs();
  // Clear through the condition route this time
  mg = '0;
  mg[4] = 1'b1;
  sum = modelAd(eAr, eArx, 1'b0);
  stepWord(ctlPkg::arSrcAd, ctlPkg::arxSrcHold, 1'b0, 1'b0, ctlPkg::specNone,
    ctlPkg::condArlInd, mg);
  eAr = {18'h0, sum[18:35]};
  checkRegs();
endtask

task automatic testMq();
  memData = randWord() | signBit;
  stepWord(ctlPkg::arSrcMem, ctlPkg::arxSrcHold, 1'b0, 1'b0, ctlPkg::specNone, '0, '0);
  eAr = memData;
  stepWord(ctlPkg::arSrcNone, ctlPkg::arxSrcHold, 1'b1, 1'b0, ctlPkg::specNone, '0, '0);
  eMq = eAr;
  checkRegs();
  // Shift sees the old AR sign while AR reloads
  memData = randWord() & ~signBit;
  stepWord(ctlPkg::arSrcMem, ctlPkg::arxSrcHold, 1'b1, 1'b0, ctlPkg::specMqShift, '0, '0);
  eMq = {eMq[1:35], eAr[0]};
  eAr = memData;
  checkRegs();
  stepWord(ctlPkg::arSrcNone, ctlPkg::arxSrcHold, 1'b1, 1'b0, ctlPkg::specMqShift, '0, '0);
  eMq = {eMq[1:35], eAr[0]};
  checkRegs();
endtask

task automatic testConsole();
  ctlPkg::wordT dIn;
  dIn = randWord();
  dIn[24] = 1'b1;
  consoleLoad(ctlPkg::diagLdReg, dIn);
  checkBit("memReset", memReset, 1'b1);
  checkBit("diagDriving", diagDriving, 1'b0);
  readBack(7'o107, dIn[24:28]);
  dIn = randWord();
  consoleLoad(ctlPkg::diagArLoad, dIn);
  eAr = dIn;
  checkRegs();
  crAr = ctlPkg::arSrcMem;
  crArx = ctlPkg::arxSrcAr;
  crMq = 1'b1;
  crSpec = ctlPkg::specArlInd;
  readBack(7'o100, 5'b01111);
  idleWord();
  crSpec = ctlPkg::specXcryAr0;
  crCond = ctlPkg::condArClr;
  readBack(7'o101, {2'b11, 2'b00, eAr[0]});
  idleWord();
  crAdCarry = 1'b1;
  crSpec = ctlPkg::specMqShift;
  crCond = ctlPkg::condArxClr;
  readBack(7'o101, 5'b00111);
  idleWord();
  crAr = ctlPkg::arSrcMem;
  readBack(7'o103, 5'b00000);
  idleWord();
  @(negedge CTL);
  checkWord("diagDataOut", diagDataOut, '0);
  checkBit("diagDriving", diagDriving, 1'b0);
  checkRegs();
endtask

// ==== tb/ctlTb.sv ====
`timescale 1ns/1ps

module ctlTb;

  localparam int numTests = 6;
  // 40 cycles per test plus the reset cycles
  localparam int cycleLimit = 40 * numTests + 3;
  localparam ctlPkg::wordT signBit = 36'h8_0000_0000;

  logic CTL;
  logic reset;
  logic step;
  ctlPkg::arFieldT crAr;
  ctlPkg::arxFieldT crArx;
  logic crMq;
  logic crAdCarry;
  ctlPkg::specT crSpec;
  ctlPkg::condT crCond;
  ctlPkg::magicT crMagic;
  ctlPkg::wordT memData;
  ctlPkg::diagFuncT diagFunc;
  logic diagStrobe;
  ctlPkg::wordT diagDataIn;

  ctlPkg::wordT ar;
  ctlPkg::wordT arx;
  ctlPkg::wordT mq;
  ctlPkg::wordT diagDataOut;
  logic diagDriving;
  logic memReset;

  // Expected register contents
  ctlPkg::wordT eAr;
  ctlPkg::wordT eArx;
  ctlPkg::wordT eMq;

  logic [31:0] lfsr = 32'he543_4fa6;
  int cycles;
  int testCount = 0;
  int checkCount = 0;
  int errorCount = 0;
  int testErrors = 0;

  ctlTop ctlTop_i (
    .CTL(CTL),
    .reset(reset),
    .step(step),
    .crAr(crAr),
    .crArx(crArx),
    .crMq(crMq),
    .crAdCarry(crAdCarry),
    .crSpec(crSpec),
    .crCond(crCond),
    .crMagic(crMagic),
    .memData(memData),
    .diagFunc(diagFunc),
    .diagStrobe(diagStrobe),
    .diagDataIn(diagDataIn),
    .ar(ar),
    .arx(arx),
    .mq(mq),
    .diagDataOut(diagDataOut),
    .diagDriving(diagDriving),
    .memReset(memReset)
  );

  initial begin
    CTL = 1'b0;
    forever begin
      #50 CTL = ~CTL;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < cycleLimit) begin
      @(posedge CTL);
      cycles++;
    end
    $display("Timeout: run still going after %0d cycles", cycles);
    $display("Test failed");
    $finish;
  end

  task automatic checkWord(input string name, input ctlPkg::wordT got, input ctlPkg::wordT exp);
    checkCount++;
    assert (got === exp) else begin
      $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      testErrors++;
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    checkCount++;
    assert (got === exp) else begin
      $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      testErrors++;
    end
  endtask

  task automatic checkRegs();
    checkWord("ar", ar, eAr);
    checkWord("arx", arx, eArx);
    checkWord("mq", mq, eMq);
  endtask

  task automatic idleWord();
    crAr = ctlPkg::arSrcNone;
    crArx = ctlPkg::arxSrcHold;
    crMq = 1'b0;
    crAdCarry = 1'b0;
    crSpec = ctlPkg::specNone;
    crCond = '0;
    crMagic = '0;
  endtask

  // Called on a falling edge, returns on the falling edge after the step
  task automatic stepWord(
    input ctlPkg::arFieldT a,
    input ctlPkg::arxFieldT x,
    input logic m,
    input logic c,
    input ctlPkg::specT s,
    input ctlPkg::condT cd,
    input ctlPkg::magicT mg
  );
    crAr = a;
    crArx = x;
    crMq = m;
    crAdCarry = c;
    crSpec = s;
    crCond = cd;
    crMagic = mg;
    step = 1'b1;
    @(negedge CTL);
    step = 1'b0;
    idleWord();
  endtask

  task automatic endTest(input string name);
    testCount++;
    errorCount += testErrors;
    if (testErrors == 0) begin
      $display("%s: pass", name);
    end else begin
      $display("%s: %0d errors", name, testErrors);
    end
    testErrors = 0;
  endtask

  `include "ctlTbTasks.svh"

  initial begin
    reset = 1'b1;
    step = 1'b0;
    idleWord();
    memData = '0;
    diagFunc = '0;
    diagStrobe = 1'b0;
    diagDataIn = '0;
    repeat (3) @(posedge CTL);
    @(negedge CTL);
    reset = 1'b0;

    testReset();
    endTest("reset");
    testLoadsAd();
    endTest("loads and AD");
    testCond();
    endTest("condition codes");
    testIndirect();
    endTest("indirect left half");
    testMq();
    endTest("MQ");
    testConsole();
    endTest("console");

    $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
